// File: design/cpu_macros.svh
////////////////////////////////////////////////////////////////////////////
// cpu macros
// widths, program memory depth and control byte fields of the 8-bit CPU
////////////////////////////////////////////////////////////////////////////

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and program memory geometry
`define CPU_DATA_W    8
`define CPU_ADDR_W    4
`define CPU_MEM_DEPTH 16
`define CPU_OPCODE_W  4

// control byte on uio_in
`define CPU_RUN_BIT   7
`define CPU_MODE_HI   5
`define CPU_MODE_LO   4

// mode field value that writes the program memory
`define CPU_MODE_LOAD 2'b01

`endif

// File: design/cpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// cpu package
// data types, opcode set and decoded control word of the 8-bit CPU
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0]   data_t;
  typedef logic [`CPU_ADDR_W-1:0]   addr_t;
  typedef logic [`CPU_OPCODE_W-1:0] nibble_t;

  // upper nibble of an instruction
  // codes C to F act as NOP
  typedef enum nibble_t {
    OP_NOP    = 4'h0,
    OP_LDA_LO = 4'h1,
    OP_LDA_HI = 4'h2,
    OP_LDB_LO = 4'h3,
    OP_LDB_HI = 4'h4,
    OP_LDC_LO = 4'h5,
    OP_LDC_HI = 4'h6,
    OP_ADD    = 4'h7,
    OP_SUB    = 4'h8,
    OP_MUL    = 4'h9,
    OP_OUT    = 4'hA,
    OP_IN     = 4'hB
  } opcode_e;

  typedef enum logic [1:0] {REG_A, REG_B, REG_C} reg_sel_e;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_e;

  // decoded strobes for one cycle that stay low while the CPU is stopped
  typedef struct packed {
    logic     imm_we;
    logic     imm_hi;
    reg_sel_e imm_sel;
    nibble_t  imm_val;
    logic     in_we;
    logic     alu_we;
    alu_op_e  alu_op;
    logic     out_we;
    reg_sel_e io_sel;
  } ctrl_t;

endpackage

`default_nettype wire

// File: design/cpu_control.sv
////////////////////////////////////////////////////////////////////////////
// cpu control
// program counter and single cycle instruction decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_control import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  run,
  input  data_t instr,
  output addr_t pc,
  output ctrl_t ctrl
);

  opcode_e opcode;
  nibble_t operand;
  logic    io_valid;

  assign opcode   = opcode_e'(instr[`CPU_DATA_W-1 -: `CPU_OPCODE_W]);
  assign operand  = instr[`CPU_OPCODE_W-1:0];
  // only A, B and C can be picked by IN and OUT
  assign io_valid = (operand <= nibble_t'(2));

  // wraps from 15 back to 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc + 1'b1;
    end
  end

  always_comb begin
    ctrl = '0;
    if (run) begin
      ctrl.imm_val = operand;
      ctrl.io_sel  = reg_sel_e'(operand[1:0]);
      case (opcode)
        OP_LDA_LO, OP_LDA_HI: begin
          ctrl.imm_we  = 1'b1;
          ctrl.imm_sel = REG_A;
          ctrl.imm_hi  = (opcode == OP_LDA_HI);
        end
        OP_LDB_LO, OP_LDB_HI: begin
          ctrl.imm_we  = 1'b1;
          ctrl.imm_sel = REG_B;
          ctrl.imm_hi  = (opcode == OP_LDB_HI);
        end
        OP_LDC_LO, OP_LDC_HI: begin
          ctrl.imm_we  = 1'b1;
          ctrl.imm_sel = REG_C;
          ctrl.imm_hi  = (opcode == OP_LDC_HI);
        end
        OP_ADD: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_ADD;
        end
        OP_SUB: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_SUB;
        end
        OP_MUL: begin
          ctrl.alu_we = 1'b1;
          ctrl.alu_op = ALU_MUL;
        end
        OP_OUT: ctrl.out_we = io_valid;
        OP_IN:  ctrl.in_we  = io_valid;
        // NOP and the unused codes
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/program_memory.sv
////////////////////////////////////////////////////////////////////////////
// program memory
// 16 byte store, written from outside while stopped, read by fetch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module program_memory import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_we,
  input  addr_t load_addr,
  input  data_t load_data,
  input  addr_t pc,
  output data_t instr
);

  data_t mem [`CPU_MEM_DEPTH];

  // a cleared byte decodes as NOP
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch is combinational so the instruction executes at the next edge
  assign instr = mem[pc];

endmodule

`default_nettype wire

// File: design/register_file.sv
////////////////////////////////////////////////////////////////////////////
// register file
// registers A, B, C and the held output byte, one write per clock
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  ctrl_t ctrl,
  input  data_t in_data,
  input  data_t alu_result,
  output data_t reg_a,
  output data_t reg_b,
  output data_t out_byte
);

  data_t reg_c;
  data_t io_value;

  // replace one half of a register with the immediate nibble
  function automatic data_t load_nibble(data_t cur, logic hi, nibble_t val);
    data_t nxt;
    nxt = cur;
    if (hi) begin
      nxt[`CPU_DATA_W-1 -: `CPU_OPCODE_W] = val;
    end else begin
      nxt[`CPU_OPCODE_W-1:0] = val;
    end
    return nxt;
  endfunction

  // source for OUT
  always_comb begin
    case (ctrl.io_sel)
      REG_A:   io_value = reg_a;
      REG_B:   io_value = reg_b;
      REG_C:   io_value = reg_c;
      default: io_value = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a    <= '0;
      reg_b    <= '0;
      reg_c    <= '0;
      out_byte <= '0;
    end else if (ctrl.imm_we) begin
      case (ctrl.imm_sel)
        REG_A:   reg_a <= load_nibble(reg_a, ctrl.imm_hi, ctrl.imm_val);
        REG_B:   reg_b <= load_nibble(reg_b, ctrl.imm_hi, ctrl.imm_val);
        REG_C:   reg_c <= load_nibble(reg_c, ctrl.imm_hi, ctrl.imm_val);
        default: ;
      endcase
    end else if (ctrl.in_we) begin
      // ui_in sampled at this edge
      case (ctrl.io_sel)
        REG_A:   reg_a <= in_data;
        REG_B:   reg_b <= in_data;
        REG_C:   reg_c <= in_data;
        default: ;
      endcase
    end else if (ctrl.alu_we) begin
      reg_c <= alu_result;
    end else if (ctrl.out_we) begin
      out_byte <= io_value;
    end
  end

endmodule

`default_nettype wire

// File: design/cpu_alu.sv
////////////////////////////////////////////////////////////////////////////
// cpu alu
// add, subtract and low byte multiply of A and B
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_alu import cpu_pkg::*; (
  input  data_t   a,
  input  data_t   b,
  input  alu_op_e op,
  output data_t   result
);

  data_t sum;
  data_t diff;
  data_t product;

  // all results wrap modulo 256
  assign sum     = a + b;
  assign diff    = a - b;
  assign product = a * b;

  always_comb begin
    case (op)
      ALU_SUB: result = diff;
      ALU_MUL: result = product;
      default: result = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// cpu top
// accumulator CPU with a 16 byte program memory in the tile pin frame
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_top import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  data_t ui_in,
  input  data_t uio_in,
  input  logic  ena,
  output data_t uo_out,
  output data_t uio_out,
  output data_t uio_oe
);

  logic  run;
  logic  load_we;
  addr_t load_addr;
  addr_t pc;
  data_t instr;
  ctrl_t ctrl;
  data_t reg_a;
  data_t reg_b;
  data_t alu_result;

  // run level, mode field and load address from the control byte
  assign run       = uio_in[`CPU_RUN_BIT];
  assign load_we   = !run && (uio_in[`CPU_MODE_HI:`CPU_MODE_LO] == `CPU_MODE_LOAD);
  assign load_addr = uio_in[`CPU_ADDR_W-1:0];

  // bidirectional pins stay inputs
  assign uio_out = '0;
  assign uio_oe  = '0;

  cpu_control u_control (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .instr (instr),
    .pc    (pc),
    .ctrl  (ctrl)
  );

  program_memory u_memory (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (ui_in),
    .pc        (pc),
    .instr     (instr)
  );

  register_file u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .in_data    (ui_in),
    .alu_result (alu_result),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .out_byte   (uo_out)
  );

  cpu_alu u_alu (
    .a      (reg_a),
    .b      (reg_b),
    .op     (ctrl.alu_op),
    .result (alu_result)
  );

endmodule

`default_nettype wire

// File: bench/cpu_sva.sv
////////////////////////////////////////////////////////////////////////////
// cpu assertions
// decode strobes and program counter behavior, bound into cpu_control
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_sva import cpu_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  run,
  input addr_t pc,
  input ctrl_t ctrl
);

  logic [3:0] strobes;

  assign strobes = {ctrl.imm_we, ctrl.in_we, ctrl.alu_we, ctrl.out_we};

  // decode stays quiet while stopped
  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !run |-> (strobes == 4'b0000))
    else $error("write strobe high while run is low");

  // register file applies a single write per clock
  a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(strobes))
    else $error("more than one write strobe high in a cycle");

  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !run |=> $stable(pc))
    else $error("pc moved while run was low");

  // wraps from the last program byte to address 0
  a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
    run |=> (pc == addr_t'(($past(pc) + 1) % `CPU_MEM_DEPTH)))
    else $error("pc did not advance by one while running");

endmodule

bind cpu_control cpu_sva u_sva (
  .clk   (clk),
  .rst_n (rst_n),
  .run   (run),
  .pc    (pc),
  .ctrl  (ctrl)
);

`default_nettype wire

// File: bench/tb_cpu.sv
////////////////////////////////////////////////////////////////////////////
// cpu testbench
// loads random programs, runs them with pauses and compares uo_out
// against an instruction-set model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int RESET_CYCLES   = 16;
  localparam int NUM_PROGRAMS   = 40;
  localparam int LOAD_CYCLES    = 16;
  localparam int RUN_CYCLES     = 40;
  localparam int TIMEOUT_CYCLES =
    RESET_CYCLES + NUM_PROGRAMS * (LOAD_CYCLES + RUN_CYCLES) + 200;

  logic  clk;
  logic  rst_n;
  logic  ena;
  data_t ui_in;
  data_t uio_in;
  data_t uo_out;
  data_t uio_out;
  data_t uio_oe;

  // instruction-set model state
  data_t m_mem [16];
  data_t m_a;
  data_t m_b;
  data_t m_c;
  data_t m_out;
  addr_t m_pc;

  data_t  prog [16];
  integer seed;
  int     errors;
  int     checks;
  int     cycle_count = 0;

  cpu_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .ena     (ena),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles, errors %0d",
               TIMEOUT_CYCLES, errors);
      $display("sim failed");
      $finish;
    end
  end

  function automatic data_t rand_byte();
    return data_t'($random(seed));
  endfunction

  function automatic nibble_t rand_nibble();
    data_t r;
    r = rand_byte();
    return r[3:0];
  endfunction

  task automatic check(input string name, input data_t actual, input data_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: actual 0x%02h expected 0x%02h at %0t",
               name, actual, expected, $time);
    end
  endtask

  // applies what the DUT does at the edge that samples these inputs
  task automatic model_step(input logic go, input logic [1:0] mode,
                            input addr_t addr, input data_t data);
    data_t      instr;
    logic [3:0] op;
    logic [3:0] arg;
    if (!go) begin
      if (mode == 2'b01) begin
        m_mem[addr] = data;
      end
    end else begin
      instr = m_mem[m_pc];
      op    = instr[7:4];
      arg   = instr[3:0];
      case (op)
        4'h1: m_a[3:0] = arg;
        4'h2: m_a[7:4] = arg;
        4'h3: m_b[3:0] = arg;
        4'h4: m_b[7:4] = arg;
        4'h5: m_c[3:0] = arg;
        4'h6: m_c[7:4] = arg;
        4'h7: m_c = m_a + m_b;
        4'h8: m_c = m_a - m_b;
        4'h9: m_c = m_a * m_b;
        4'hA: begin
          if (arg == 4'd0) m_out = m_a;
          if (arg == 4'd1) m_out = m_b;
          if (arg == 4'd2) m_out = m_c;
        end
        4'hB: begin
          if (arg == 4'd0) m_a = data;
          if (arg == 4'd1) m_b = data;
          if (arg == 4'd2) m_c = data;
        end
        default: ;
      endcase
      m_pc = m_pc + 1'b1;
    end
  endtask

  // uo_out at the negedge reflects the inputs of the previous call
  task automatic step_cycle(input logic go, input logic [1:0] mode,
                            input addr_t addr, input data_t data);
    data_t expected;
    data_t r;
    r = rand_byte();
    @(posedge clk);
    // bit 6 carries random noise that the DUT ignores
    uio_in <= {go, r[0], mode, addr};
    ui_in  <= data;
    expected = m_out;
    model_step(go, mode, addr, data);
    @(negedge clk);
    check("uo_out", uo_out, expected);
  endtask

  task automatic load_program();
    for (int i = 0; i < LOAD_CYCLES; i++) begin
      step_cycle(1'b0, 2'b01, addr_t'(i), prog[i]);
    end
  endtask

  // run mostly high, with random pauses that sometimes patch a byte
  task automatic run_program();
    data_t      r;
    logic       go;
    logic [1:0] mode;
    for (int i = 0; i < RUN_CYCLES; i++) begin
      r  = rand_byte();
      go = (r[2:0] != 3'd0);
      if (go) begin
        mode = r[4:3];
      end else begin
        mode = (r[7:4] == 4'h0) ? 2'b01 : 2'b00;
      end
      step_cycle(go, mode, addr_t'(rand_nibble()), rand_byte());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // program builders
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_load_program();
    data_t r;
    for (int i = 0; i < 13; i++) begin
      r = rand_byte();
      prog[i] = {4'(1 + (r % 6)), rand_nibble()};
    end
    prog[13] = 8'hA0;
    prog[14] = 8'hA1;
    prog[15] = 8'hA2;
  endtask

  task automatic build_arith_program();
    prog[0] = {4'h1, rand_nibble()};
    prog[1] = {4'h2, rand_nibble()};
    prog[2] = {4'h3, rand_nibble()};
    prog[3] = {4'h4, rand_nibble()};
    prog[4] = 8'h70;
    prog[5] = 8'hA2;
    prog[6] = 8'h80;
    prog[7] = 8'hA2;
    prog[8] = 8'h90;
    prog[9] = 8'hA2;
    prog[10] = 8'hA0;
    prog[11] = 8'hA1;
    for (int i = 12; i < 16; i++) begin
      prog[i] = {4'hA, 4'(rand_byte() % 3)};
    end
  endtask

  task automatic build_input_program();
    logic [3:0] sel;
    for (int i = 0; i < 3; i++) begin
      prog[2*i]     = {4'hB, 4'(i)};
      prog[2*i + 1] = {4'hA, 4'(i)};
    end
    // invalid operands and unused opcodes
    prog[6]  = {4'hB, 4'(3 + (rand_byte() % 13))};
    prog[7]  = {4'hA, 4'(3 + (rand_byte() % 13))};
    prog[8]  = {4'(12 + (rand_byte() % 4)), rand_nibble()};
    prog[9]  = {4'(12 + (rand_byte() % 4)), rand_nibble()};
    prog[10] = 8'hA0;
    prog[11] = 8'hA1;
    prog[12] = 8'hA2;
    sel = 4'(rand_byte() % 3);
    prog[13] = {4'hB, sel};
    prog[14] = {4'hA, sel};
    prog[15] = 8'h00;
  endtask

  task automatic build_random_program();
    for (int i = 0; i < 16; i++) begin
      prog[i] = rand_byte();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed   = 32'h9491_a822;
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    ena    = 1'b1;
    ui_in  = '0;
    uio_in = '0;
    for (int i = 0; i < 16; i++) begin
      m_mem[i] = '0;
    end
    m_a   = '0;
    m_b   = '0;
    m_c   = '0;
    m_out = '0;
    m_pc  = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("uo_out", uo_out, 8'h00);
    check("uio_out", uio_out, 8'h00);
    check("uio_oe", uio_oe, 8'h00);

    // an empty memory runs as NOPs
    for (int i = 0; i < 16; i++) begin
      step_cycle(1'b1, 2'b00, 4'h0, rand_byte());
    end

    for (int p = 0; p < NUM_PROGRAMS; p++) begin
      case (p % 4)
        0: build_load_program();
        1: build_arith_program();
        2: build_input_program();
        default: build_random_program();
      endcase
      load_program();
      run_program();
    end

    // one idle cycle shows the effect of the last instruction
    step_cycle(1'b0, 2'b00, 4'h0, 8'h00);
    check("uio_out", uio_out, 8'h00);
    check("uio_oe", uio_oe, 8'h00);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/cpu_pkg.sv
design/cpu_control.sv
design/program_memory.sv
design/register_file.sv
design/cpu_alu.sv
design/cpu_top.sv
bench/cpu_sva.sv
bench/tb_cpu.sv
